// ==== flist.f ====
+incdir+src
src/rename_pkg.sv
src/cdb_arbiter.sv
src/rob.sv
src/rat.sv
src/rename_core.sv
verification/tb_rename_core.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - include_dirs:
      - src
    files:
      - src/rename_pkg.sv
      - src/cdb_arbiter.sv
      - src/rob.sv
      - src/rat.sv
      - src/rename_core.sv
  - target: test
    files:
      - verification/tb_rename_core.sv

// ==== verification/tb_rename_core.sv ====
// Testbench for the rename and retire slice, table driven against a reference model
`timescale 1ns/1ps

module tb_rename_core;

  localparam int NSTEPS = 22;

  // One row holds a rename, port loads and expected {src1, src2} readiness
  typedef struct {
    int ren;
    int rd;
    int rs1;
    int rs2;
    int la;
    int ta;
    int lb;
    int tb;
    int err;
    int rdy;
  } step_t;

  logic                    clk;
  logic                    rst;
  logic                    rename_valid;
  rename_pkg::rename_req_t rename_req;
  logic                    rename_ready;
  logic                    wb_a_valid;
  rename_pkg::wb_t         wb_a;
  logic                    wb_a_ready;
  logic                    wb_b_valid;
  rename_pkg::wb_t         wb_b;
  logic                    wb_b_ready;
  logic                    src_valid;
  rename_pkg::src_opnd_t   src1;
  rename_pkg::src_opnd_t   src2;
  rename_pkg::retire_t     retire;
  logic                    flush;

  // Column order ren rd rs1 rs2 la ta lb tb err rdy
  // An rd of 32 means no destination
  step_t steps [NSTEPS] = '{
    '{1, 5, 5, 0, 0, 0, 0, 0, 0, 2'b11},
    '{1, 6, 5, 7, 0, 0, 0, 0, 0, 2'b11},
    '{1, 32, 6, 5, 1, 0, 0, 0, 0, 2'b11},
    '{1, 7, 5, 6, 0, 0, 1, 1, 0, 2'b11},
    '{1, 8, 7, 6, 0, 0, 0, 0, 0, 2'b11},
    '{0, 0, 0, 0, 1, 3, 0, 0, 0, 0},
    '{0, 0, 0, 0, 1, 2, 1, 4, 0, 0},
    '{1, 9, 8, 9, 0, 0, 0, 0, 0, 2'b11},
    '{1, 10, 9, 10, 0, 0, 0, 0, 0, 2'b11},
    '{0, 0, 0, 0, 1, 6, 1, 5, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{1, 32, 10, 9, 0, 0, 0, 0, 0, 2'b11},
    '{1, 5, 0, 0, 0, 0, 0, 0, 0, 2'b11},
    '{0, 0, 0, 0, 1, 8, 1, 7, 1, 0},
    '{1, 11, 5, 11, 0, 0, 0, 0, 0, 2'b01},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{1, 12, 5, 9, 0, 0, 0, 0, 0, 2'b11},
    '{1, 13, 12, 10, 0, 0, 1, 0, 0, 2'b11},
    '{0, 0, 0, 0, 1, 1, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
  };

  // Reference model of committed values and newest producer per register
  logic [31:0]       m_comm   [32];
  bit                has_prod [32];
  int                prod     [32];
  // Per tag destination, completion and result
  rename_pkg::dest_t m_rd     [16];
  bit                m_done   [16];
  bit                m_err    [16];
  logic [31:0]       m_res    [16];
  int                rob_q    [$];
  int                tail;
  bit                prio_b;
  // Operands captured at rename and resolved a cycle later
  bit                op_pend;
  bit                op_has   [2];
  int                op_tag   [2];
  logic [31:0]       op_val   [2];
  int                op_rdy;
  // Ports holding a payload until granted
  bit                a_hold;
  bit                b_hold;
  logic [15:0]       lfsr;
  int                checks;
  int                errors;

  rename_core DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // Result word built one LFSR bit at a time
  task automatic load_wb(input int t, input int err, output rename_pkg::wb_t w);
    w.robid = t[3:0];
    w.rd    = m_rd[t];
    w.error = err[0];
    for (int i = 0; i < 32; i++) begin
      lfsr     = lfsr_next(lfsr);
      w.result = {w.result[30:0], lfsr[0]};
    end
  endtask

  // Upper bound on run time
  initial begin
    #((NSTEPS * 20 + 16) * 20);
    $display("Timeout: the step table did not complete in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    step_t               st;
    bit                  ga;
    bit                  gb;
    bit                  bc_v;
    bit                  e_flush;
    bit                  e_rdy;
    rename_pkg::wb_t     bc;
    rename_pkg::retire_t e_ret;
    rename_pkg::src_opnd_t act;
    logic [31:0]         e_word;
    int                  r;
    int                  h;
    rst          = 1'b1;
    rename_valid = 1'b0;
    rename_req   = '0;
    wb_a_valid   = 1'b0;
    wb_a         = '0;
    wb_b_valid   = 1'b0;
    wb_b         = '0;
    lfsr         = 16'd33179;
    tail         = 0;
    prio_b       = 1'b0;
    op_pend      = 1'b0;
    a_hold       = 1'b0;
    b_hold       = 1'b0;
    checks       = 0;
    errors       = 0;
    for (int i = 0; i < 32; i++) begin
      m_comm[i]   = '0;
      has_prod[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      m_done[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    // Idle outputs right after reset
    #16;
    check("reset rename_ready", 1, rename_ready);
    check("reset src_valid", 0, src_valid);
    check("reset retire.valid", 0, retire.valid);
    check("reset flush", 0, flush);
    check("reset wb readys", 0, {wb_a_ready, wb_b_ready});
    for (int k = 0; k < NSTEPS; k++) begin
      @(posedge clk);
      #2;
      st           = steps[k];
      rename_valid = st.ren[0];
      rename_req   = {st.rd[5:0], st.rs1[4:0], st.rs2[4:0]};
      if (st.la != 0) begin
        a_hold = 1'b1;
        load_wb(st.ta, st.err, wb_a);
      end
      if (st.lb != 0) begin
        b_hold = 1'b1;
        load_wb(st.tb, 0, wb_b);
      end
      wb_a_valid = a_hold;
      wb_b_valid = b_hold;
      // Lone port wins and ties go by rotating priority
      ga   = a_hold && (!b_hold || !prio_b);
      gb   = b_hold && (!a_hold || prio_b);
      bc_v = ga || gb;
      bc   = gb ? wb_b : wb_a;
      // Oldest entry leaves once done and an error means flush
      e_ret   = '0;
      e_flush = 1'b0;
      if (rob_q.size() > 0 && m_done[rob_q[0]]) begin
        h = rob_q[0];
        if (m_err[h]) begin
          e_flush = 1'b1;
        end else begin
          e_ret.valid  = 1'b1;
          e_ret.rd     = m_rd[h].idx;
          e_ret.has_rd = !m_rd[h].none;
          e_ret.result = m_res[h];
        end
      end
      #16;
      check($sformatf("step %0d rename_ready", k), 1, rename_ready);
      check($sformatf("step %0d wb_a_ready", k), ga, wb_a_ready);
      check($sformatf("step %0d wb_b_ready", k), gb, wb_b_ready);
      check($sformatf("step %0d src_valid", k), op_pend, src_valid);
      check($sformatf("step %0d flush", k), e_flush, flush);
      check($sformatf("step %0d retire.valid", k), e_ret.valid, retire.valid);
      if (e_ret.valid) begin
        check($sformatf("step %0d retire", k), e_ret, retire);
      end
      if (op_pend) begin
        for (int s = 0; s < 2; s++) begin
          act = (s == 0) ? src1 : src2;
          if (op_has[s]) begin
            h     = op_tag[s];
            // Error results are never forwarded
            e_rdy = (m_done[h] && !m_err[h]) || (bc_v && bc.robid == h && !bc.error);
            if (!e_rdy) begin
              e_word = h;
            end else if (m_done[h]) begin
              e_word = m_res[h];
            end else begin
              e_word = bc.result;
            end
          end else begin
            e_word = op_val[s];
          end
          check($sformatf("step %0d src%0d ready", k, s + 1), (op_rdy >> (1 - s)) & 1,
                act.ready);
          check($sformatf("step %0d src%0d word", k, s + 1), e_word, act.word);
        end
      end
      // Sources read the old mapping from before this rename's destination
      op_pend = st.ren[0];
      op_rdy  = st.rdy;
      for (int s = 0; s < 2; s++) begin
        r         = (s == 0) ? st.rs1 : st.rs2;
        op_has[s] = (r != 0) && has_prod[r];
        op_tag[s] = prod[r];
        op_val[s] = m_comm[r];
      end
      if (e_ret.valid) begin
        h = rob_q.pop_front();
        if (e_ret.has_rd) begin
          m_comm[e_ret.rd] = e_ret.result;
          if (has_prod[e_ret.rd] && prod[e_ret.rd] == h) begin
            has_prod[e_ret.rd] = 1'b0;
          end
        end
      end
      if (bc_v) begin
        m_done[bc.robid] = 1'b1;
        m_err[bc.robid]  = bc.error;
        m_res[bc.robid]  = bc.result;
      end
      if (ga) begin
        a_hold = 1'b0;
      end
      if (gb) begin
        b_hold = 1'b0;
      end
      if (st.ren != 0) begin
        h         = tail;
        m_rd[h]   = st.rd[5:0];
        m_done[h] = 1'b0;
        rob_q.push_back(h);
        tail = (tail + 1) % 16;
        if (st.rd[5] == 0 && st.rd[4:0] != 0) begin
          has_prod[st.rd[4:0]] = 1'b1;
          prod[st.rd[4:0]]     = h;
        end
      end
      // Priority turns over after each contended grant
      if (wb_a_valid && wb_b_valid) begin
        prio_b = !prio_b;
      end
      // Flush empties the buffer and returns every register to committed
      if (e_flush) begin
        rob_q.delete();
        tail = 0;
        for (int i = 0; i < 32; i++) begin
          has_prod[i] = 1'b0;
        end
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== src/rename_core.sv ====
// Rename and retire top level joining the alias table, reorder buffer and bus arbiter
`timescale 1ns/1ps

module rename_core (
  input  logic                    clk,
  input  logic                    rst,
  // Rename port
  input  logic                    rename_valid,
  input  rename_pkg::rename_req_t rename_req,
  output logic                    rename_ready,
  // Writeback ports
  input  logic                    wb_a_valid,
  input  rename_pkg::wb_t         wb_a,
  output logic                    wb_a_ready,
  input  logic                    wb_b_valid,
  input  rename_pkg::wb_t         wb_b,
  output logic                    wb_b_ready,
  // Operands, one cycle after rename
  output logic                    src_valid,
  output rename_pkg::src_opnd_t   src1,
  output rename_pkg::src_opnd_t   src2,
  // Retirement
  output rename_pkg::retire_t     retire,
  output logic                    flush
);

  logic                rename_fire;
  rename_pkg::rob_id_t alloc_robid;
  rename_pkg::cdb_t    cdb;

  assign rename_fire = rename_valid & rename_ready;

  cdb_arbiter u_cdb_arbiter (
    .clk     (clk),
    .rst     (rst),
    .a_valid (wb_a_valid),
    .b_valid (wb_b_valid),
    .a_wb    (wb_a),
    .b_wb    (wb_b),
    .a_ready (wb_a_ready),
    .b_ready (wb_b_ready),
    .cdb     (cdb)
  );

  rob u_rob (
    .clk          (clk),
    .rst          (rst),
    .rename_valid (rename_valid),
    .rename_req   (rename_req),
    .rename_ready (rename_ready),
    .alloc_robid  (alloc_robid),
    .cdb          (cdb),
    .retire       (retire),
    .flush        (flush)
  );

  // Table sees the tag in the same cycle it is handed out
  rat u_rat (
    .clk          (clk),
    .rst          (rst),
    .rename_fire  (rename_fire),
    .rename_req   (rename_req),
    .rename_robid (alloc_robid),
    .cdb          (cdb),
    .retire       (retire),
    .flush        (flush),
    .src_valid    (src_valid),
    .src1         (src1),
    .src2         (src2)
  );

endmodule

// ==== src/rat.sv ====
// Register alias table holding tags, speculative and committed values with CDB forwarding
`timescale 1ns/1ps
`include "rename_config.svh"

module rat (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rename_fire,
  input  rename_pkg::rename_req_t rename_req,
  input  rename_pkg::rob_id_t     rename_robid,
  input  rename_pkg::cdb_t        cdb,
  input  rename_pkg::retire_t     retire,
  input  logic                    flush,
  output logic                    src_valid,
  output rename_pkg::src_opnd_t   src1,
  output rename_pkg::src_opnd_t   src2
);

  // Snapshot of one source register taken at rename
  typedef struct packed {
    logic                    valid;
    logic                    committed;
    rename_pkg::rob_id_t     tag;
    logic [`RENAME_XLEN-1:0] spec;
    logic [`RENAME_XLEN-1:0] comm;
  } rd_slot_t;

  // Last cycle's bus beat, second chance for forwarding
  typedef struct packed {
    logic                    write;
    rename_pkg::rob_id_t     robid;
    rename_pkg::reg_idx_t    rd;
    logic [`RENAME_XLEN-1:0] result;
  } prev_cdb_t;

  // Per-register state
  logic [`RENAME_XLEN-1:0]     comm_val [`RENAME_NUM_REGS];
  logic [`RENAME_XLEN-1:0]     spec_val [`RENAME_NUM_REGS];
  rename_pkg::rob_id_t         tag      [`RENAME_NUM_REGS];
  logic [`RENAME_NUM_REGS-1:0] reg_valid;
  logic [`RENAME_NUM_REGS-1:0] reg_committed;

  // Source read path, slot 0 is rs1 and slot 1 is rs2
  rename_pkg::reg_idx_t  src_idx [2];
  rd_slot_t              rd_q    [2];
  rename_pkg::src_opnd_t opnd    [2];
  logic [1:0]            fwd_cur;
  logic [1:0]            fwd_prev;

  prev_cdb_t prev_q;
  logic      cdb_write;
  logic      ld_tag;
  logic      ld_spec;

  assign src_idx[0] = rename_req.rs1;
  assign src_idx[1] = rename_req.rs2;

  // Error results never reach the table, their instruction gets flushed
  assign cdb_write = cdb.valid & ~cdb.wb.error & ~cdb.wb.rd.none;
  // x0 is never renamed
  assign ld_tag = rename_fire & ~rename_req.rd.none & (rename_req.rd.idx != '0);
  // Spec write only if the broadcaster is still the newest producer
  assign ld_spec = prev_q.write & (prev_q.rd != '0) & (tag[prev_q.rd] == prev_q.robid);

  // Registered source reads
  always_ff @(posedge clk) begin
    for (int s = 0; s < 2; s++) begin
      if (rename_fire) begin
        if (src_idx[s] == '0) begin
          // Hardwired zero
          rd_q[s] <= '{valid: 1'b1, committed: 1'b1, tag: '0, spec: '0, comm: '0};
        end else begin
          rd_q[s].committed <= reg_committed[src_idx[s]];
          rd_q[s].tag       <= tag[src_idx[s]];
          rd_q[s].comm      <= comm_val[src_idx[s]];
          // Bypass the spec write landing this same cycle
          if (ld_spec && prev_q.rd == src_idx[s]) begin
            rd_q[s].valid <= 1'b1;
            rd_q[s].spec  <= prev_q.result;
          end else begin
            rd_q[s].valid <= reg_valid[src_idx[s]];
            rd_q[s].spec  <= spec_val[src_idx[s]];
          end
        end
      end
    end
  end

  // Committed values and tags
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `RENAME_NUM_REGS; r++) begin
        comm_val[r] <= '0;
        tag[r]      <= '0;
      end
    end else begin
      if (retire.valid && retire.has_rd) begin
        comm_val[retire.rd] <= retire.result;
      end
      if (ld_tag) begin
        tag[rename_req.rd.idx] <= rename_robid;
      end
    end
  end

  // Speculative values, written one cycle after the broadcast
  always_ff @(posedge clk) begin
    if (ld_spec) begin
      spec_val[prev_q.rd] <= prev_q.result;
    end
  end

  // Valid and committed bits, reset and flush win
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      reg_valid     <= '1;
      reg_committed <= '1;
    end else begin
      if (ld_spec) begin
        reg_valid[prev_q.rd] <= 1'b1;
      end
      // New producer overrides a same-cycle spec write
      if (ld_tag) begin
        reg_valid[rename_req.rd.idx]     <= 1'b0;
        reg_committed[rename_req.rd.idx] <= 1'b0;
      end
    end
  end

  // Keep the bus beat around for one more cycle
  always_ff @(posedge clk) begin
    prev_q.robid  <= cdb.wb.robid;
    prev_q.rd     <= cdb.wb.rd.idx;
    prev_q.result <= cdb.wb.result;
    if (rst || flush) begin
      prev_q.write <= 1'b0;
    end else begin
      prev_q.write <= cdb_write;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      src_valid <= 1'b0;
    end else begin
      src_valid <= rename_fire;
    end
  end

  // Operand select: committed, speculative, forwarded, else bare tag
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      fwd_cur[s]    = cdb_write & (cdb.wb.robid == rd_q[s].tag);
      fwd_prev[s]   = prev_q.write & (prev_q.robid == rd_q[s].tag);
      opnd[s].ready = rd_q[s].valid | fwd_cur[s] | fwd_prev[s];
      if (rd_q[s].committed) begin
        opnd[s].word.value = rd_q[s].comm;
      end else if (rd_q[s].valid) begin
        opnd[s].word.value = rd_q[s].spec;
      end else if (fwd_prev[s]) begin
        opnd[s].word.value = prev_q.result;
      end else if (fwd_cur[s]) begin
        opnd[s].word.value = cdb.wb.result;
      end else begin
        opnd[s].word.tag.pad = '0;
        opnd[s].word.tag.id  = rd_q[s].tag;
      end
    end
  end

  assign src1 = opnd[0];
  assign src2 = opnd[1];

  // Committed implies valid for every register
  a_committed_valid: assert property (@(posedge clk) disable iff (rst)
    (reg_committed & ~reg_valid) == '0);

  // Back-to-back operands need back-to-back renames
  a_src_valid_pair: assert property (@(posedge clk) disable iff (rst)
    src_valid && $past(src_valid) |-> $past(rename_fire) && $past(rename_fire, 2));

endmodule

// ==== src/rob.sv ====
// Reorder buffer that hands out tags, collects CDB results and retires in order
`timescale 1ns/1ps
`include "rename_config.svh"

module rob (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rename_valid,
  input  rename_pkg::rename_req_t rename_req,
  output logic                    rename_ready,
  output rename_pkg::rob_id_t     alloc_robid,
  input  rename_pkg::cdb_t        cdb,
  output rename_pkg::retire_t     retire,
  output logic                    flush
);

  // Entry payload, done bits kept apart as control state
  typedef struct packed {
    logic                    error;
    rename_pkg::dest_t       rd;
    logic [`RENAME_XLEN-1:0] result;
  } rob_entry_t;

  rob_entry_t                    ent [`RENAME_ROB_ENTRIES];
  logic [`RENAME_ROB_ENTRIES-1:0] done;

  rename_pkg::rob_id_t      head;
  rename_pkg::rob_id_t      tail;
  logic [`RENAME_ROB_ID_W:0] count;

  logic full;
  logic alloc;
  logic head_done;
  logic retire_go;

  assign full         = (count == `RENAME_ROB_ENTRIES);
  assign rename_ready = ~full;
  // Tag is simply the tail slot
  assign alloc_robid  = tail;
  assign alloc        = rename_valid & rename_ready;

  // Head can leave once its result is in
  assign head_done = (count != '0) & done[head];
  assign retire_go = head_done;

  // Error at the head squashes everything, including its own write
  assign flush = head_done & ent[head].error;

  always_comb begin
    retire.valid  = head_done & ~ent[head].error;
    retire.rd     = ent[head].rd.idx;
    retire.has_rd = ~ent[head].rd.none;
    retire.result = ent[head].result;
  end

  // Pointers, occupancy and done bits
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (alloc) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (cdb.valid) begin
        done[cdb.wb.robid] <= 1'b1;
      end
      if (retire_go) begin
        head <= head + 1'b1;
      end
      case ({alloc, retire_go})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Destination at allocation, result and error at writeback
  always_ff @(posedge clk) begin
    if (alloc) begin
      ent[tail].rd <= rename_req.rd;
    end
    if (cdb.valid) begin
      ent[cdb.wb.robid].error  <= cdb.wb.error;
      ent[cdb.wb.robid].result <= cdb.wb.result;
    end
  end

  // Bus only carries tags that are in flight
  a_cdb_allocated: assert property (@(posedge clk) disable iff (rst)
    cdb.valid |-> (rename_pkg::rob_id_t'(cdb.wb.robid - head) < count));

  // Occupancy bound
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= `RENAME_ROB_ENTRIES);

endmodule

// ==== src/cdb_arbiter.sv ====
// Round-robin arbiter granting the common data bus to one of two writeback ports
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  logic                a_valid,
  input  logic                b_valid,
  input  rename_pkg::wb_t     a_wb,
  input  rename_pkg::wb_t     b_wb,
  output logic                a_ready,
  output logic                b_ready,
  output rename_pkg::cdb_t    cdb
);

  // Set when port b wins the next tie
  logic prio_b;
  logic grant_a;
  logic grant_b;
  logic contend;

  assign contend = a_valid & b_valid;

  // Lone requester always wins, ties go by priority
  assign grant_a = a_valid & (~b_valid | ~prio_b);
  assign grant_b = b_valid & (~a_valid | prio_b);

  // Ready in the grant cycle, loser holds its payload
  assign a_ready = grant_a;
  assign b_ready = grant_b;

  always_comb begin
    cdb.valid = grant_a | grant_b;
    if (grant_b) begin
      cdb.wb = b_wb;
    end else begin
      cdb.wb = a_wb;
    end
  end

  // Flip only after a contended grant, port a first after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_b <= 1'b0;
    end else if (contend) begin
      prio_b <= ~prio_b;
    end
  end

  // One port per cycle on the bus
  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    !(a_ready && b_ready));

endmodule

// ==== src/rename_pkg.sv ====
// Rename package with request, writeback, bus, retire and operand types
`include "rename_config.svh"

package rename_pkg;

  // Architectural register index
  typedef logic [`RENAME_REG_W-1:0] reg_idx_t;

  // Reorder buffer tag
  typedef logic [`RENAME_ROB_ID_W-1:0] rob_id_t;

  // Destination field, none set means no register write
  typedef struct packed {
    logic     none;
    reg_idx_t idx;
  } dest_t;

  // One instruction entering rename
  typedef struct packed {
    dest_t    rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } rename_req_t;

  // Result from an execution port
  typedef struct packed {
    rob_id_t                 robid;
    dest_t                   rd;
    logic                    error;
    logic [`RENAME_XLEN-1:0] result;
  } wb_t;

  // Common data bus beat
  typedef struct packed {
    logic valid;
    wb_t  wb;
  } cdb_t;

  // In-order retirement record
  typedef struct packed {
    logic                    valid;
    reg_idx_t                rd;
    logic                    has_rd;
    logic [`RENAME_XLEN-1:0] result;
  } retire_t;

  // Operand word, a value when ready and a zero-extended tag otherwise
  typedef union packed {
    logic [`RENAME_XLEN-1:0] value;
    struct packed {
      logic [`RENAME_XLEN-`RENAME_ROB_ID_W-1:0] pad;
      rob_id_t                                  id;
    } tag;
  } tagval_u;

  // Source operand handed to the issue stage
  typedef struct packed {
    logic    ready;
    tagval_u word;
  } src_opnd_t;

endpackage

// ==== src/rename_config.svh ====
// Rename slice sizing macros for data width, register file and reorder buffer depth
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Datapath width
`define RENAME_XLEN 32

// Architectural register file
`define RENAME_NUM_REGS 32

// Index width for the architectural registers
`define RENAME_REG_W 5

// Reorder buffer depth, kept a power of two so pointers wrap on their own
`define RENAME_ROB_ENTRIES 16

// Reorder buffer tag width
`define RENAME_ROB_ID_W 4

`endif
